//--- design/concat_defs.svh
// shared widths, depths and credit counts; include in any file that sizes concat stage logic
`ifndef CONCAT_DEFS_SVH
`define CONCAT_DEFS_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// one feature word per branch per pixel
`define CONCAT_DATA_WIDTH 32
// inception style branch count
`define CONCAT_NUM_BRANCH 5
// enough bits to name every branch
`define CONCAT_BRANCH_ID_WIDTH 3

////////////////////////////////////////
// buffering and credits
////////////////////////////////////////

// words per branch FIFO, also the upstream credit per branch
`define CONCAT_FIFO_DEPTH 8
// downstream credit after reset
`define CONCAT_OUT_CREDITS 4
// holds the largest credit count and the FIFO occupancy
`define CONCAT_CREDIT_WIDTH 4

`endif

//--- design/concat_ctrl_pkg.sv
// control enums for the concat stage: branch names and sequencer states
`include "concat_defs.svh"

package concat_ctrl_pkg;

  ////////////////////////////////////////
  // branch identifiers
  ////////////////////////////////////////

  // output order within a pixel follows this encoding
  typedef enum logic [`CONCAT_BRANCH_ID_WIDTH-1:0] {
    BRANCH_0 = 3'd0,
    BRANCH_1 = 3'd1,
    BRANCH_2 = 3'd2,
    BRANCH_3 = 3'd3,
    BRANCH_4 = 3'd4
  } branch_id_e;

  // sequencer status, one per cycle
  typedef enum logic [1:0] {
    SEQ_WAIT_DATA   = 2'd0,
    SEQ_WAIT_CREDIT = 2'd1,
    SEQ_ISSUE       = 2'd2
  } seq_state_e;

endpackage

//--- design/concat_beat_pkg.sv
// beat types carried between branches, FIFOs, sequencer and the output port of the concat stage
`include "concat_defs.svh"

package concat_beat_pkg;

  ////////////////////////////////////////
  // branch side
  ////////////////////////////////////////

  // one word from one branch
  typedef struct packed {
    logic                          valid;
    logic [`CONCAT_DATA_WIDTH-1:0] data;
  } branch_beat_t;

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  // one word of the joined stream
  // last marks the final branch word of a pixel
  typedef struct packed {
    logic                          valid;
    logic [`CONCAT_DATA_WIDTH-1:0] data;
    concat_ctrl_pkg::branch_id_e   branch;
    logic                          last;
  } out_beat_t;

endpackage

//--- design/branch_ingress.sv
// branch ingress: checks each branch word against its upstream credit and registers it into its FIFO
`timescale 1ns/10ps
`include "concat_defs.svh"

module branch_ingress (
  input  logic                         clk,
  input  logic                         reset,
  // raw words from the five branches
  input  concat_beat_pkg::branch_beat_t branch_in [`CONCAT_NUM_BRANCH],
  // one pulse per FIFO pop, per branch
  input  logic [`CONCAT_NUM_BRANCH-1:0] credit_back,
  // registered writes toward the branch FIFOs
  output concat_beat_pkg::branch_beat_t fifo_wr [`CONCAT_NUM_BRANCH],
  // sticky, set by a word that found no credit
  output logic [`CONCAT_NUM_BRANCH-1:0] overflow
);

  // credit value after reset, one full FIFO worth
  localparam logic [`CONCAT_CREDIT_WIDTH-1:0] INIT_CREDIT =
    `CONCAT_CREDIT_WIDTH'(`CONCAT_FIFO_DEPTH);

  ////////////////////////////////////////
  // per branch credit check
  ////////////////////////////////////////

  for (genvar b = 0; b < `CONCAT_NUM_BRANCH; b++) begin : g_branch
    logic [`CONCAT_CREDIT_WIDTH-1:0] credit;
    logic                            has_credit;
    logic                            accept;
    logic                            drop;

    // a word only goes in while a FIFO slot is reserved for it
    assign has_credit = (credit != '0);
    assign accept     = branch_in[b].valid && has_credit;
    assign drop       = branch_in[b].valid && !has_credit;

    // credit counter
    always_ff @(posedge clk) begin
      if (reset) begin
        credit <= INIT_CREDIT;
      end else begin
        case ({credit_back[b], accept})
          // pop returned a slot, nothing spent
          2'b10: credit <= credit + 1'b1;
          // slot spent, nothing returned
          2'b01: credit <= credit - 1'b1;
          // both or neither leave it as is
          default: credit <= credit;
        endcase
      end
    end

    // write strobe, control state
    always_ff @(posedge clk) begin
      if (reset) begin
        fifo_wr[b].valid <= 1'b0;
      end else begin
        fifo_wr[b].valid <= accept;
      end
    end

    // payload follows the strobe, no reset needed
    always_ff @(posedge clk) begin
      if (accept) begin
        fifo_wr[b].data <= branch_in[b].data;
      end
    end

    // overflow latch, cleared only by reset
    always_ff @(posedge clk) begin
      if (reset) begin
        overflow[b] <= 1'b0;
      end else if (drop) begin
        overflow[b] <= 1'b1;
      end
    end
  end

endmodule

//--- design/branch_fifo.sv
// one branch FIFO: holds ingress words until the sequencer pops them, returns a credit per pop
`timescale 1ns/10ps
`include "concat_defs.svh"

module branch_fifo (
  input  logic                          clk,
  input  logic                          reset,
  // registered write from ingress
  input  concat_beat_pkg::branch_beat_t wr,
  // from the sequencer, only when not empty
  input  logic                          pop,
  // word at the read pointer
  output logic [`CONCAT_DATA_WIDTH-1:0] head,
  output logic                          empty,
  // one cycle pulse, one cycle after each pop
  output logic                          credit_out
);

  localparam int DEPTH = `CONCAT_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  ////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////

  logic [`CONCAT_DATA_WIDTH-1:0]   mem [DEPTH];
  logic [PTR_W-1:0]                wr_ptr;
  logic [PTR_W-1:0]                rd_ptr;
  logic [`CONCAT_CREDIT_WIDTH-1:0] count;
  logic                            full;
  logic                            do_wr;
  logic                            do_rd;

  assign empty = (count == '0);
  assign full  = (count == `CONCAT_CREDIT_WIDTH'(DEPTH));
  // upstream credits keep writes off a full buffer
  assign do_wr = wr.valid && !full;
  assign do_rd = pop && !empty;
  assign head  = mem[rd_ptr];

  // data array
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr.data;
    end
  end

  // pointers wrap at the last slot
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // occupancy and credit return
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      count      <= '0;
      credit_out <= 1'b0;
    end else begin
      // simultaneous write and read keep the count
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
      credit_out <= do_rd;
    end
  end

endmodule

//--- design/concat_sequencer.sv
// concat sequencer: pops branch FIFOs in fixed round order and issues output beats under credit
`timescale 1ns/10ps
`include "concat_defs.svh"

module concat_sequencer (
  input  logic                          clk,
  input  logic                          reset,
  // FIFO heads and empty flags, indexed by branch
  input  logic [`CONCAT_DATA_WIDTH-1:0] head [`CONCAT_NUM_BRANCH],
  input  logic [`CONCAT_NUM_BRANCH-1:0] empty,
  // one pulse per word the consumer absorbed
  input  logic                          out_credit,
  // one-hot or zero
  output logic [`CONCAT_NUM_BRANCH-1:0] pop,
  output concat_beat_pkg::out_beat_t    out_beat
);

  localparam logic [`CONCAT_CREDIT_WIDTH-1:0] INIT_CREDIT =
    `CONCAT_CREDIT_WIDTH'(`CONCAT_OUT_CREDITS);

  ////////////////////////////////////////
  // round state
  ////////////////////////////////////////

  concat_ctrl_pkg::seq_state_e     state;
  concat_ctrl_pkg::seq_state_e     state_next;
  concat_ctrl_pkg::branch_id_e     cur_branch;
  logic [`CONCAT_CREDIT_WIDTH-1:0] credits;
  logic                            issue;
  logic                            cur_empty;
  logic                            cur_last;
  // registered beat payload
  logic [`CONCAT_DATA_WIDTH-1:0]   out_data;
  concat_ctrl_pkg::branch_id_e     out_branch;
  logic                            out_last;

  assign cur_empty = empty[cur_branch];
  assign cur_last  = (cur_branch == concat_ctrl_pkg::BRANCH_4);

  // data first, then credit
  always_comb begin
    if (cur_empty) begin
      state_next = concat_ctrl_pkg::SEQ_WAIT_DATA;
    end else if (credits == '0) begin
      state_next = concat_ctrl_pkg::SEQ_WAIT_CREDIT;
    end else begin
      state_next = concat_ctrl_pkg::SEQ_ISSUE;
    end
  end

  assign issue = (state_next == concat_ctrl_pkg::SEQ_ISSUE);
  // only the branch whose turn it is
  assign pop   = issue ? (`CONCAT_NUM_BRANCH'(1) << cur_branch) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= concat_ctrl_pkg::SEQ_WAIT_DATA;
      cur_branch <= concat_ctrl_pkg::BRANCH_0;
    end else begin
      state <= state_next;
      if (issue) begin
        // wrap after the fifth branch, next pixel
        cur_branch <= cur_last ? concat_ctrl_pkg::BRANCH_0
                               : concat_ctrl_pkg::branch_id_e'(cur_branch + 1'b1);
      end
    end
  end

  ////////////////////////////////////////
  // downstream credit
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= INIT_CREDIT;
    end else if (out_credit && !issue) begin
      credits <= credits + 1'b1;
    end else if (issue && !out_credit) begin
      credits <= credits - 1'b1;
    end
  end

  // popped word lands on the output one edge later
  always_ff @(posedge clk) begin
    if (issue) begin
      out_data   <= head[cur_branch];
      out_branch <= cur_branch;
      out_last   <= cur_last;
    end
  end

  // valid straight from the issue state
  always_comb begin
    out_beat.valid  = (state == concat_ctrl_pkg::SEQ_ISSUE);
    out_beat.data   = out_data;
    out_beat.branch = out_branch;
    out_beat.last   = out_last;
  end

endmodule

//--- design/concat_stage.sv
// concat stage top: joins five credit-controlled branch streams into one ordered feature stream
`timescale 1ns/10ps
`include "concat_defs.svh"

module concat_stage (
  input  logic                          clk,
  input  logic                          reset,
  // one word per branch per pixel
  input  concat_beat_pkg::branch_beat_t branch_in [`CONCAT_NUM_BRANCH],
  // consumer credit return
  input  logic                          out_credit,
  // upstream credit return, one pulse per pop
  output logic [`CONCAT_NUM_BRANCH-1:0] in_credit,
  output concat_beat_pkg::out_beat_t    out_beat,
  output logic [`CONCAT_NUM_BRANCH-1:0] overflow
);

  ////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////

  concat_beat_pkg::branch_beat_t fifo_wr [`CONCAT_NUM_BRANCH];
  logic [`CONCAT_DATA_WIDTH-1:0] fifo_head [`CONCAT_NUM_BRANCH];
  logic [`CONCAT_NUM_BRANCH-1:0] fifo_empty;
  logic [`CONCAT_NUM_BRANCH-1:0] fifo_pop;

  // producer, credit check and write register
  branch_ingress i_branch_ingress (
    .clk         (clk),
    .reset       (reset),
    .branch_in   (branch_in),
    .credit_back (in_credit),
    .fifo_wr     (fifo_wr),
    .overflow    (overflow)
  );

  // buffer, one FIFO per branch
  for (genvar b = 0; b < `CONCAT_NUM_BRANCH; b++) begin : g_fifo
    // credit pulse feeds both the upstream and ingress
    branch_fifo i_branch_fifo (
      .clk        (clk),
      .reset      (reset),
      .wr         (fifo_wr[b]),
      .pop        (fifo_pop[b]),
      .head       (fifo_head[b]),
      .empty      (fifo_empty[b]),
      .credit_out (in_credit[b])
    );
  end

  // consumer, round order and downstream credit
  concat_sequencer i_concat_sequencer (
    .clk        (clk),
    .reset      (reset),
    .head       (fifo_head),
    .empty      (fifo_empty),
    .out_credit (out_credit),
    .pop        (fifo_pop),
    .out_beat   (out_beat)
  );

endmodule

//--- tb/concat_properties.sv
// concurrent assertions bound into the concat stage; pop shape, downstream credit, branch order
`timescale 1ns/10ps
`include "concat_defs.svh"

module concat_properties (
  input logic                          clk,
  input logic                          reset,
  input logic [`CONCAT_NUM_BRANCH-1:0] pop,
  input logic [`CONCAT_NUM_BRANCH-1:0] empty,
  input logic                          out_credit,
  input concat_beat_pkg::out_beat_t    out_beat
);

  // shadow of the sequencer credit counter
  logic [`CONCAT_CREDIT_WIDTH-1:0] credit_model;
  concat_ctrl_pkg::branch_id_e     prev_branch;
  concat_ctrl_pkg::branch_id_e     next_branch;

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_model <= `CONCAT_CREDIT_WIDTH'(`CONCAT_OUT_CREDITS);
    end else if (out_credit && pop == '0) begin
      credit_model <= credit_model + 1'b1;
    end else if (!out_credit && pop != '0) begin
      credit_model <= credit_model - 1'b1;
    end
  end

  // branch of the last valid beat
  // reset to branch 4 so the first pixel starts at branch 0
  always_ff @(posedge clk) begin
    if (reset) begin
      prev_branch <= concat_ctrl_pkg::BRANCH_4;
    end else if (out_beat.valid) begin
      prev_branch <= out_beat.branch;
    end
  end

  assign next_branch = (prev_branch == concat_ctrl_pkg::BRANCH_4) ? concat_ctrl_pkg::BRANCH_0
                     : concat_ctrl_pkg::branch_id_e'(prev_branch + 1'b1);

  ////////////////////////////////////////
  // rules
  ////////////////////////////////////////

  // at most one FIFO, and never one with nothing to give
  pop_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(pop) && ((pop & empty) == '0))
    else $error("pop selects more than one branch FIFO or an empty one");

  // beat shows up one edge after the pop that spent a credit
  valid_has_credit: assert property (@(posedge clk) disable iff (reset)
    out_beat.valid |-> $past(credit_model != '0))
    else $error("output beat issued with no downstream credit");

  branch_in_order: assert property (@(posedge clk) disable iff (reset)
    out_beat.valid |-> (out_beat.branch == next_branch))
    else $error("output beat branch breaks the round order");

endmodule

bind concat_stage concat_properties i_concat_properties (
  .clk        (clk),
  .reset      (reset),
  .pop        (fifo_pop),
  .empty      (fifo_empty),
  .out_credit (out_credit),
  .out_beat   (out_beat)
);

//--- tb/concat_tb.sv
// testbench for the concat stage; table driven pixels, credit models on both sides, scoreboard
`timescale 1ns/10ps
`include "concat_defs.svh"

module concat_tb;

  localparam int NB          = `CONCAT_NUM_BRANCH;
  localparam int DW          = `CONCAT_DATA_WIDTH;
  localparam int NUM_NORMAL  = 12;
  localparam int NUM_STALL   = 10;
  localparam int NUM_ROWS    = NUM_NORMAL + NUM_STALL + 1;
  localparam int MAX_DELAY   = 3;
  // rows x branches x worst delay plus settle and drain time
  localparam int CYCLE_LIMIT = NUM_ROWS * NB * (MAX_DELAY + 1) + 600;
  localparam logic [1:0] ROW_NORMAL = 2'd0;
  localparam logic [1:0] ROW_STALL  = 2'd1;
  localparam logic [1:0] ROW_FORCE  = 2'd2;

  // one pixel of stimulus
  typedef struct packed {
    logic [NB-1:0][DW-1:0] words;
    logic [NB-1:0][1:0]    delay;
    logic [7:0]            grant;
    logic [1:0]            kind;
  } stim_row_t;

  // one scoreboard entry
  typedef struct packed {
    logic [DW-1:0] data;
    logic [2:0]    branch;
    logic          last;
  } exp_beat_t;

  logic                          clk;
  logic                          reset;
  concat_beat_pkg::branch_beat_t branch_in [NB];
  logic                          out_credit;
  logic [NB-1:0]                 in_credit;
  concat_beat_pkg::out_beat_t    out_beat;
  logic [NB-1:0]                 overflow;

  stim_row_t     table_rows [NUM_ROWS];
  exp_beat_t     exp_q [$];
  int            sent_count [NB];
  int            returned_count [NB];
  int            branch_beats [NB];
  int            beats_seen = 0;
  int            credits_given = 0;
  int            grant_phase = 0;
  int            cycles = 0;
  int            value_errors = 0;
  int            other_errors = 0;
  logic [7:0]    grant_pattern;
  logic [NB-1:0] forced_mask;
  logic          idle_window;
  logic [31:0]   rng;

  concat_stage i_concat_stage (
    .clk        (clk),
    .reset      (reset),
    .branch_in  (branch_in),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .out_beat   (out_beat),
    .overflow   (overflow)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // upstream credit as the branch sees it
  function automatic int credit_left(input int b);
    return `CONCAT_FIFO_DEPTH - sent_count[b] + returned_count[b];
  endfunction

  function automatic logic all_have_credit();
    logic ok;
    ok = 1'b1;
    for (int b = 0; b < NB; b++) begin
      if (credit_left(b) == 0) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("FAIL %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic clear_inputs();
    for (int b = 0; b < NB; b++) begin
      branch_in[b] <= '0;
    end
  endtask

  task automatic build_table();
    stim_row_t row;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = '0;
      for (int b = 0; b < NB; b++) begin
        rng = xorshift32(rng);
        row.words[b] = rng;
        rng = xorshift32(rng);
        // first pixel aligned, later ones skewed
        row.delay[b] = (r == 0) ? 2'd0 : rng[1:0];
      end
      rng = xorshift32(rng);
      if (r < NUM_NORMAL) begin
        row.kind  = ROW_NORMAL;
        // bit 0 kept so credit flow never stops for good
        row.grant = (r % 4 == 0) ? 8'hFF : (rng[7:0] | 8'h01);
      end else if (r < NUM_NORMAL + NUM_STALL) begin
        row.kind  = ROW_STALL;
        row.grant = 8'h00;
      end else begin
        row.kind  = ROW_FORCE;
        row.grant = 8'h00;
      end
      table_rows[r] = row;
    end
  endtask

  // send a word on every branch that has run dry
  task automatic force_overflow(input stim_row_t row);
    logic [NB-1:0] mask;
    mask = '0;
    // let pops still holding downstream credit finish
    repeat (10) @(posedge clk);
    for (int b = 0; b < NB; b++) begin
      if (credit_left(b) == 0) begin
        branch_in[b] <= '{valid: 1'b1, data: row.words[b]};
        mask[b] = 1'b1;
      end else begin
        branch_in[b] <= '0;
      end
    end
    forced_mask = mask;
    assert (mask != '0) else begin
      $display("force row at %0t ns found credit left on every branch", $time);
      other_errors++;
    end
    @(posedge clk);
    clear_inputs();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("overflow", 32'(overflow), 32'(mask));
  endtask

  task automatic apply_row(input stim_row_t row);
    logic [NB-1:0] pending;
    int            step;
    grant_pattern <= row.grant;
    if (row.kind == ROW_FORCE) begin
      force_overflow(row);
    end else if (row.kind == ROW_NORMAL || all_have_credit()) begin
      // a stall row without room on every branch stays out of the stream
      for (int b = 0; b < NB; b++) begin
        exp_q.push_back(exp_beat_t'{data: row.words[b], branch: 3'(b), last: (b == NB - 1)});
      end
      pending = '1;
      step    = 0;
      while (pending != '0) begin
        @(posedge clk);
        for (int b = 0; b < NB; b++) begin
          if (pending[b] && step >= int'(row.delay[b]) && credit_left(b) > 0) begin
            branch_in[b] <= '{valid: 1'b1, data: row.words[b]};
            sent_count[b]++;
            pending[b] = 1'b0;
          end else begin
            branch_in[b] <= '0;
          end
        end
        step++;
      end
      @(posedge clk);
      clear_inputs();
    end
  endtask

  task automatic check_beat();
    exp_beat_t want;
    beats_seen++;
    assert (exp_q.size() > 0) else begin
      $display("output beat at %0t ns with no word left in the scoreboard", $time);
      other_errors++;
    end
    if (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      // per branch tally of delivered words, taken from the table
      branch_beats[want.branch]++;
      check_value("out_beat.data", out_beat.data, want.data);
      check_value("out_beat.branch", 32'(out_beat.branch), 32'(want.branch));
      check_value("out_beat.last", 32'(out_beat.last), 32'(want.last));
    end
  endtask

  ////////////////////////////////////////
  // clock, timeout, consumer, monitor
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, run did not finish", CYCLE_LIMIT);
    $display("Errors found");
    $finish;
  end

  // downstream consumer returns one credit per absorbed word when the pattern allows
  initial begin
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset && beats_seen > credits_given && grant_pattern[grant_phase]) begin
        out_credit <= 1'b1;
        credits_given++;
      end else begin
        out_credit <= 1'b0;
      end
      grant_phase = (grant_phase + 1) % 8;
    end
  end

  // outputs sampled mid cycle
  initial begin
    forever begin
      @(negedge clk);
      if (!reset) begin
        for (int b = 0; b < NB; b++) begin
          if (in_credit[b]) begin
            returned_count[b]++;
          end
        end
        if (idle_window) begin
          check_value("out_beat.valid", 32'(out_beat.valid), 32'd0);
          check_value("in_credit", 32'(in_credit), 32'd0);
          check_value("overflow", 32'(overflow), 32'd0);
        end
        if (out_beat.valid) begin
          check_beat();
        end
        assert ((overflow & ~forced_mask) == '0) else begin
          $display("overflow set at %0t ns on a branch that still had credit", $time);
          other_errors++;
        end
        assert (beats_seen <= `CONCAT_OUT_CREDITS + credits_given) else begin
          $display("%0d output beats by %0t ns against %0d downstream credits",
                   beats_seen, $time, `CONCAT_OUT_CREDITS + credits_given);
          other_errors++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    reset         = 1'b1;
    grant_pattern = 8'hFF;
    idle_window   = 1'b0;
    forced_mask   = '0;
    rng           = 32'd5839;
    for (int b = 0; b < NB; b++) begin
      branch_in[b]      = '0;
      sent_count[b]     = 0;
      returned_count[b] = 0;
      branch_beats[b]   = 0;
    end
    build_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // quiet outputs while nothing is sent
    idle_window = 1'b1;
    repeat (6) @(posedge clk);
    idle_window = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(table_rows[r]);
    end
    // credits flow freely for the drain
    grant_pattern <= 8'hFF;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(negedge clk);
    for (int b = 0; b < NB; b++) begin
      check_value($sformatf("in_credit[%0d] pulses", b), returned_count[b], branch_beats[b]);
    end
    check_value("overflow", 32'(overflow), 32'(forced_mask));
    $display("check summary: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the concat stage testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module concat_tb --Mdir "$BUILD_DIR" -o concat_sim -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/concat_sim" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG_FILE"; then
  echo "result: FAILED"
  exit 1
fi

echo "result: PASSED"
exit 0

//--- tb.f
+incdir+design
design/concat_ctrl_pkg.sv
design/concat_beat_pkg.sv
design/branch_ingress.sv
design/branch_fifo.sv
design/concat_sequencer.sv
design/concat_stage.sv
tb/concat_properties.sv
tb/concat_tb.sv
